// ==== coll_stage.f ====
common/coll_pkg.sv
common/coll_stage_if.sv
hdl/comm_table.sv
route_resolver/route_resolver.sv
hdl/tree_fanout.sv
hdl/flit_assembler.sv
hdl/coll_stage.sv
tests/tb_coll_stage.sv

// ==== common/coll_pkg.sv ====
`default_nettype none

package coll_pkg;

  ////////////////////
  // field widths
  localparam int coord_w    = 3;
  localparam int rank_w     = 9;   // one rank number, also one x/y/z triple
  localparam int ctx_w      = 8;
  localparam int tag_w      = 8;
  localparam int op_w       = 4;
  localparam int payload_w  = 32;
  localparam int children_w = 3;
  localparam int lg_size_w  = 4;   // lg of communicator size
  localparam int cfg_addr_w = 8;
  localparam int cfg_data_w = 22;  // one full comm entry
  localparam int ext_w      = 16;  // wide enough for 2^15 communicator size

  typedef logic [children_w-1:0] children_t;
  typedef logic [ext_w-1:0]      ext_rank_t;

  // algorithm type field of the flit
  typedef enum logic [1:0] {
    alg_ring     = 2'd0,
    alg_tree     = 2'd1,
    alg_doubling = 2'd2,
    alg_bcast    = 2'd3
  } alg_e;

  ////////////////////
  // flit layouts, msb first
  typedef struct packed {
    logic                 valid;    // bit 72
    logic [coord_w-1:0]   dst_z;
    logic [coord_w-1:0]   dst_y;
    logic [coord_w-1:0]   dst_x;
    logic [coord_w-1:0]   src_z;
    logic [coord_w-1:0]   src_y;
    logic [coord_w-1:0]   src_x;
    logic [ctx_w-1:0]     context_id;
    logic [tag_w-1:0]     tag;
    alg_e                 algtype;
    logic [op_w-1:0]      op;
    logic [payload_w-1:0] payload;  // bits 31..0
  } flit_t;

  typedef struct packed {
    children_t children;  // bits 75..73
    flit_t     flit;
  } out_flit_t;

  // one rank table entry
  typedef struct packed {
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    logic [coord_w-1:0] z;
  } coord_t;

  // one communicator table entry
  typedef struct packed {
    logic [rank_w-1:0]    local_rank;
    logic [lg_size_w-1:0] lg_commsize;
    logic [rank_w-1:0]    base_rank;
  } comm_entry_t;

  ////////////////////
  // helpers shared by both lookup paths
  function automatic ext_rank_t comm_size(logic [lg_size_w-1:0] lg);
    return ext_rank_t'(1) << lg;  // S = 2^lg
  endfunction

  // local rank mod S
  function automatic ext_rank_t rel_rank(comm_entry_t e);
    return ext_rank_t'(e.local_rank) & (comm_size(e.lg_commsize) - ext_rank_t'(1));
  endfunction

endpackage

`default_nettype wire

// ==== common/coll_stage_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// communicator entry for the context on packet_in, combinational
interface comm_lookup_if;
  coll_pkg::comm_entry_t entry;

  modport source (output entry);  // comm_table
  modport sink   (input  entry);  // route_resolver, tree_fanout
endinterface

// stage 1 flit with new destination
interface dest_if;
  coll_pkg::flit_t flit;  // registered

  modport source (output flit);
  modport sink   (input  flit);
endinterface

// stage 1 children count plus valid level
interface fanout_if;
  coll_pkg::children_t children;
  logic                valid;

  modport source (
    output children,
    output valid
  );
  modport sink (
    input children,
    input valid
  );
endinterface

`default_nettype wire

// ==== hdl/coll_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

// collective stage, 2 cycle latency, one flit per cycle
module coll_stage #(
  parameter int comm_entries = 4,
  parameter int lg_ranks     = 3   // 8 ranks
) (
  input  wire                                  clk,
  input  wire                                  rst,
  input  coll_pkg::flit_t                      packet_in,
  input  wire                                  cfg_comm_we,  // comm table strobe
  input  wire                                  cfg_rank_we,  // rank table strobe
  input  wire logic [coll_pkg::cfg_addr_w-1:0] cfg_addr,
  input  wire logic [coll_pkg::cfg_data_w-1:0] cfg_data,
  output coll_pkg::out_flit_t                  packet_out
);

  comm_lookup_if lookup_bus ();
  dest_if        dest_bus ();
  fanout_if      fanout_bus ();

  ////////////////////
  // stage 0, comm lookup
  comm_table #(
    .comm_entries (comm_entries)
  ) u_comm_table (
    .clk         (clk),
    .rst         (rst),
    .cfg_comm_we (cfg_comm_we),
    .cfg_addr    (cfg_addr),
    .cfg_data    (cfg_data),
    .context_id  (packet_in.context_id),
    .lookup      (lookup_bus.source)
  );

  ////////////////////
  // stage 1, two paths side by side
  route_resolver #(
    .lg_ranks (lg_ranks)
  ) u_route_resolver (
    .clk         (clk),
    .rst         (rst),
    .cfg_rank_we (cfg_rank_we),
    .cfg_addr    (cfg_addr),
    .cfg_data    (cfg_data),
    .flit        (packet_in),
    .lookup      (lookup_bus.sink),
    .dest        (dest_bus.source)
  );

  tree_fanout u_tree_fanout (
    .clk     (clk),
    .rst     (rst),
    .algtype (packet_in.algtype),
    .valid   (packet_in.valid),
    .lookup  (lookup_bus.sink),
    .fanout  (fanout_bus.source)
  );

  ////////////////////
  // stage 2, merge
  flit_assembler u_flit_assembler (
    .clk        (clk),
    .rst        (rst),
    .dest       (dest_bus.sink),
    .fanout     (fanout_bus.sink),
    .packet_out (packet_out)
  );

endmodule

`default_nettype wire

// ==== hdl/comm_table.sv ====
`timescale 1ns/10ps
`default_nettype none

// communicator table, written from cfg port, read by context
module comm_table #(
  parameter int comm_entries = 4
) (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  cfg_comm_we,
  input  wire logic [coll_pkg::cfg_addr_w-1:0] cfg_addr,
  input  wire logic [coll_pkg::cfg_data_w-1:0] cfg_data,
  input  wire logic [coll_pkg::ctx_w-1:0]      context_id,
  comm_lookup_if.source                        lookup
);

  // at least one index bit even for a single entry
  localparam int idx_w = (comm_entries > 1) ? $clog2(comm_entries) : 1;

  coll_pkg::comm_entry_t table_q [comm_entries];

  logic [idx_w-1:0] wr_idx;
  logic [idx_w-1:0] rd_idx;

  assign wr_idx = idx_w'(cfg_addr % comm_entries);    // addr mod entries
  assign rd_idx = idx_w'(context_id % comm_entries);  // low ctx bits for 2^n entries

  ////////////////////
  // write port
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < comm_entries; i++) begin
        table_q[i] <= '0;  // all communicators empty
      end
    end else if (cfg_comm_we) begin
      table_q[wr_idx] <= coll_pkg::comm_entry_t'(cfg_data);
    end
  end

  // read is combinational, a write shows up for the next flit
  assign lookup.entry = table_q[rd_idx];

endmodule

`default_nettype wire

// ==== hdl/flit_assembler.sv ====
`timescale 1ns/10ps
`default_nettype none

// joins destination flit and children count into packet_out
module flit_assembler (
  input  wire                 clk,
  input  wire                 rst,
  dest_if.sink                dest,
  fanout_if.sink              fanout,
  output coll_pkg::out_flit_t packet_out
);

  coll_pkg::out_flit_t next_out;

  always_comb begin
    next_out.children   = fanout.children;
    next_out.flit       = dest.flit;
    // both paths registered the same valid, fanout's copy is taken
    next_out.flit.valid = fanout.valid;
  end

  ////////////////////
  // output register
  always_ff @(posedge clk) begin
    if (rst) begin
      packet_out <= '0;  // valid low after reset
    end else begin
      packet_out <= next_out;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tree_fanout.sv ====
`timescale 1ns/10ps
`default_nettype none

// children the local rank waits for, registered with valid
module tree_fanout (
  input  wire           clk,
  input  wire           rst,
  input  coll_pkg::alg_e algtype,
  input  wire           valid,
  comm_lookup_if.sink   lookup,
  fanout_if.source      fanout
);

  coll_pkg::ext_rank_t size;       // S
  coll_pkg::ext_rank_t r;          // relative rank
  coll_pkg::ext_rank_t left_kid;   // 2r+1
  coll_pkg::ext_rank_t right_kid;  // 2r+2
  logic                has_left;
  logic                has_right;
  coll_pkg::children_t tree_cnt;
  coll_pkg::children_t dbl_cnt;
  coll_pkg::children_t next_cnt;

  always_comb begin
    size      = coll_pkg::comm_size(lookup.entry.lg_commsize);
    r         = coll_pkg::rel_rank(lookup.entry);
    left_kid  = (r << 1) + coll_pkg::ext_rank_t'(1);
    right_kid = (r << 1) + coll_pkg::ext_rank_t'(2);
    has_left  = left_kid < size;
    has_right = right_kid < size;

    // binary tree, 0..2 kids
    tree_cnt = coll_pkg::children_t'(has_left) + coll_pkg::children_t'(has_right);

    // one round per doubling step, field is only 3 bits wide
    if (lookup.entry.lg_commsize > 4'd7) begin
      dbl_cnt = 3'd7;
    end else begin
      dbl_cnt = lookup.entry.lg_commsize[2:0];
    end

    case (algtype)
      coll_pkg::alg_ring:     next_cnt = 3'd1;  // one neighbour upstream
      coll_pkg::alg_doubling: next_cnt = dbl_cnt;
      default:                next_cnt = tree_cnt;  // tree and bcast
    endcase
  end

  ////////////////////
  // stage 1 register
  always_ff @(posedge clk) begin
    if (rst) begin
      fanout.children <= '0;
      fanout.valid    <= 1'b0;
    end else begin
      fanout.children <= next_cnt;
      fanout.valid    <= valid;
    end
  end

endmodule

`default_nettype wire

// ==== route_resolver/route_resolver.sv ====
`timescale 1ns/10ps
`default_nettype none

// peer rank per algorithm, rank table, registered destination
module route_resolver #(
  parameter int lg_ranks = 3
) (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  cfg_rank_we,
  input  wire logic [coll_pkg::cfg_addr_w-1:0] cfg_addr,
  input  wire logic [coll_pkg::cfg_data_w-1:0] cfg_data,
  input  coll_pkg::flit_t                      flit,
  comm_lookup_if.sink                          lookup,
  dest_if.source                               dest
);

  localparam int num_ranks = 1 << lg_ranks;

  coll_pkg::coord_t rank_tbl [num_ranks];  // rank -> torus x/y/z

  coll_pkg::ext_rank_t size;        // S
  coll_pkg::ext_rank_t r;           // local rank mod S
  coll_pkg::ext_rank_t first_child; // 2r+1
  coll_pkg::ext_rank_t p_ring;
  coll_pkg::ext_rank_t p_tree;
  coll_pkg::ext_rank_t p_doubling;
  coll_pkg::ext_rank_t p_bcast;
  coll_pkg::ext_rank_t peer;        // relative peer
  coll_pkg::ext_rank_t global_peer; // base + peer, before mod
  logic [2:0]          flip_k;      // bit to flip in doubling
  logic [lg_ranks-1:0] peer_idx;
  coll_pkg::coord_t    dst_coord;
  coll_pkg::flit_t     next_flit;

  ////////////////////
  // rank table write port
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_ranks; i++) begin
        rank_tbl[i] <= '0;
      end
    end else if (cfg_rank_we) begin
      rank_tbl[cfg_addr[lg_ranks-1:0]] <= coll_pkg::coord_t'(cfg_data[coll_pkg::rank_w-1:0]);
    end
  end

  ////////////////////
  // relative peer per algorithm
  always_comb begin
    size        = coll_pkg::comm_size(lookup.entry.lg_commsize);
    r           = coll_pkg::rel_rank(lookup.entry);
    first_child = (r << 1) + coll_pkg::ext_rank_t'(1);

    p_ring = (r + coll_pkg::ext_rank_t'(1)) & (size - coll_pkg::ext_rank_t'(1));  // wraps at S
    p_tree = (r == '0) ? '0 : ((r - coll_pkg::ext_rank_t'(1)) >> 1);               // parent, root stays

    // k from tag only if it lies inside the communicator
    flip_k = ({1'b0, flit.tag[2:0]} < lookup.entry.lg_commsize) ? flit.tag[2:0] : 3'd0;
    if (lookup.entry.lg_commsize == '0) begin
      p_doubling = r;  // single rank, talks to itself
    end else begin
      p_doubling = r ^ (coll_pkg::ext_rank_t'(1) << flip_k);
    end

    p_bcast = (first_child < size) ? first_child : r;  // leaf keeps itself

    case (flit.algtype)
      coll_pkg::alg_ring:     peer = p_ring;
      coll_pkg::alg_tree:     peer = p_tree;
      coll_pkg::alg_doubling: peer = p_doubling;
      default:                peer = p_bcast;
    endcase
  end

  // global rank, mod num_ranks by truncation
  assign global_peer = coll_pkg::ext_rank_t'(lookup.entry.base_rank) + peer;
  assign peer_idx    = global_peer[lg_ranks-1:0];
  assign dst_coord   = rank_tbl[peer_idx];

  always_comb begin
    next_flit       = flit;  // src, ctx, tag, op, payload, valid unchanged
    next_flit.dst_x = dst_coord.x;
    next_flit.dst_y = dst_coord.y;
    next_flit.dst_z = dst_coord.z;
  end

  ////////////////////
  // stage 1 register
  always_ff @(posedge clk) begin
    if (rst) begin
      dest.flit <= '0;  // keeps packet_out clean right after reset
    end else begin
      dest.flit <= next_flit;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the collective stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_coll_stage -f coll_stage.f

out=$(./obj_dir/Vtb_coll_stage) || true
printf '%s\n' "$out"

# exits non-zero when the pass line is missing
printf '%s\n' "$out" | grep -q "SIMULATION PASSED"

// ==== tests/tb_coll_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_coll_stage;

  localparam int comm_entries = 4;
  localparam int lg_ranks     = 3;
  localparam int num_ranks    = 1 << lg_ranks;

  logic                            clk;
  logic                            rst;
  coll_pkg::flit_t                 packet_in;
  logic                            cfg_comm_we;
  logic                            cfg_rank_we;
  logic [coll_pkg::cfg_addr_w-1:0] cfg_addr;
  logic [coll_pkg::cfg_data_w-1:0] cfg_data;
  coll_pkg::out_flit_t             packet_out;

  integer seed;
  string  test_name;

  coll_pkg::comm_entry_t sh_comm [comm_entries];  // shadow comm table
  coll_pkg::coord_t      sh_rank [num_ranks];     // shadow rank table
  coll_pkg::out_flit_t   exp_q [$];               // two flits in flight

  coll_stage #(
    .comm_entries (comm_entries),
    .lg_ranks     (lg_ranks)
  ) dut (
    .clk         (clk),
    .rst         (rst),
    .packet_in   (packet_in),
    .cfg_comm_we (cfg_comm_we),
    .cfg_rank_we (cfg_rank_we),
    .cfg_addr    (cfg_addr),
    .cfg_data    (cfg_data),
    .packet_out  (packet_out)
  );

  always #20 clk = ~clk;  // 40 ns period

  ////////////////////
  // stimulus helpers
  function automatic int unsigned rnd();
    return $unsigned($random(seed));
  endfunction

  function automatic coll_pkg::flit_t rand_flit(coll_pkg::alg_e alg, logic v);
    coll_pkg::flit_t f;
    logic [95:0]     bits;
    bits      = {rnd(), rnd(), rnd()};
    f         = bits[72:0];  // random dst fields get replaced
    f.algtype = alg;
    f.valid   = v;
    return f;
  endfunction

  function automatic logic [coll_pkg::cfg_data_w-1:0] comm_data(int lg);
    coll_pkg::comm_entry_t e;
    e.local_rank  = 9'(rnd());
    e.lg_commsize = 4'(lg);
    e.base_rank   = 9'(rnd());
    return e;
  endfunction

  function automatic coll_pkg::coord_t dst_of(coll_pkg::flit_t f);
    coll_pkg::coord_t c;
    c.x = f.dst_x;
    c.y = f.dst_y;
    c.z = f.dst_z;
    return c;
  endfunction

  ////////////////////
  // reference model from the peer and children rules
  function automatic coll_pkg::out_flit_t model_out(coll_pkg::flit_t f);
    coll_pkg::comm_entry_t e;
    coll_pkg::out_flit_t   o;
    coll_pkg::coord_t      c;
    int                    lg;
    int                    s;
    int                    r;
    int                    p;
    int                    k;
    int                    g;
    int                    kids;
    e  = sh_comm[int'(f.context_id) % comm_entries];
    lg = int'(e.lg_commsize);
    s  = 1 << lg;
    r  = int'(e.local_rank) % s;
    kids = 0;
    case (f.algtype)
      coll_pkg::alg_ring: begin
        p    = (r + 1) % s;
        kids = 1;
      end
      coll_pkg::alg_doubling: begin
        k = int'(f.tag) % 8;
        if (k >= lg) k = 0;  // bit outside the comm flips bit 0
        p    = (lg == 0) ? r : (r ^ (1 << k));
        kids = (lg > 7) ? 7 : lg;  // 3 bit field saturates
      end
      default: begin  // tree and bcast share the binary tree
        if (f.algtype == coll_pkg::alg_tree) p = (r == 0) ? 0 : (r - 1) / 2;
        else p = (2 * r + 1 < s) ? 2 * r + 1 : r;
        if (2 * r + 1 < s) kids++;
        if (2 * r + 2 < s) kids++;
      end
    endcase
    g = (int'(e.base_rank) + p) % num_ranks;
    c = sh_rank[g];
    o.flit       = f;
    o.flit.dst_x = c.x;
    o.flit.dst_y = c.y;
    o.flit.dst_z = c.z;
    o.children   = coll_pkg::children_t'(kids);
    return o;
  endfunction

  ////////////////////
  // compare tasks
  task automatic check_flit(string name, coll_pkg::out_flit_t exp, coll_pkg::out_flit_t act);
    if (act !== exp) begin
      $display("** Error [%s] packet_out expected %h actual %h", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_coord(string name, coll_pkg::coord_t exp, coll_pkg::coord_t act);
    if (act !== exp) begin
      $display("** Error [%s] dst x/y/z expected %h actual %h", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////
  // one clock of driving on the rising edge and checking at the falling edge
  task automatic drive_cycle(coll_pkg::flit_t f, logic cwe, logic rwe,
                             logic [7:0] addr, logic [21:0] data);
    coll_pkg::out_flit_t exp;
    @(posedge clk);
    rst         <= 1'b0;  // released together with the first flit
    packet_in   <= f;
    cfg_comm_we <= cwe;
    cfg_rank_we <= rwe;
    cfg_addr    <= addr;
    cfg_data    <= data;
    exp_q.push_back(model_out(f));  // tables as they are before this write
    if (cwe) sh_comm[int'(addr) % comm_entries] = coll_pkg::comm_entry_t'(data);
    if (rwe) sh_rank[int'(addr) % num_ranks] = coll_pkg::coord_t'(data[8:0]);
    @(negedge clk);
    exp = exp_q.pop_front();
    check_coord(test_name, dst_of(exp.flit), dst_of(packet_out.flit));
    check_flit(test_name, exp, packet_out);
  endtask

  task automatic send_flit(coll_pkg::flit_t f);
    drive_cycle(f, 1'b0, 1'b0, 8'd0, 22'd0);
  endtask

  task automatic write_comm(logic [7:0] addr, logic [21:0] data);
    drive_cycle(rand_flit(coll_pkg::alg_e'(2'(rnd())), 1'b0), 1'b1, 1'b0, addr, data);
  endtask

  task automatic write_rank(logic [7:0] addr, logic [21:0] data);
    drive_cycle(rand_flit(coll_pkg::alg_e'(2'(rnd())), 1'b0), 1'b0, 1'b1, addr, data);
  endtask

  // hard stop if something hangs
  initial begin
    for (int i = 0; i < 2000; i++) @(posedge clk);
    $display("timeout: run exceeded 2000 cycles");
    $display("SIMULATION FAILED");
    $fatal(1);
  end

  initial begin
    coll_pkg::comm_entry_t e;
    coll_pkg::flit_t       f;
    int                    sel;
    clk         = 1'b0;
    rst         = 1'b1;
    packet_in   = '0;
    cfg_comm_we = 1'b0;
    cfg_rank_we = 1'b0;
    cfg_addr    = '0;
    cfg_data    = '0;
    seed        = 32'hc3d4;
    for (int i = 0; i < comm_entries; i++) sh_comm[i] = '0;
    for (int i = 0; i < num_ranks; i++) sh_rank[i] = '0;

    ////////////////////
    // reset held for 16 edges incl. the release edge
    test_name = "reset";
    for (int i = 0; i < 15; i++) begin
      @(posedge clk);
      @(negedge clk);
      check_flit(test_name, '0, packet_out);
    end
    exp_q.push_back('0);  // pipeline still cleared after release
    exp_q.push_back('0);
    send_flit(rand_flit(coll_pkg::alg_ring, 1'b1));
    send_flit('0);  // first flit lands 2 cycles later
    send_flit('0);

    test_name = "config";
    for (int i = 0; i < num_ranks; i++) write_rank(8'(i), 22'(rnd()));
    for (int i = 0; i < comm_entries; i++) write_comm(8'(i), comm_data(int'(rnd() % 5)));

    ////////////////////
    // ring and tree with a root rank in ctx 0
    test_name     = "ring_tree";
    e             = '0;
    e.local_rank  = 9'd16;  // 16 mod 8 is 0
    e.lg_commsize = 4'd3;
    e.base_rank   = 9'(rnd());
    write_comm(8'd4, e);  // addr 4 lands on entry 0
    for (int i = 0; i < 40; i++) begin
      f = rand_flit((rnd() % 2 != 0) ? coll_pkg::alg_tree : coll_pkg::alg_ring, 1'b1);
      if (i % 4 == 0) f.context_id[1:0] = 2'b00;
      send_flit(f);
    end

    test_name = "doubling";
    write_comm(8'd1, comm_data(0));  // single rank
    write_comm(8'd2, comm_data(11)); // children saturate
    write_comm(8'd3, comm_data(int'(1 + rnd() % 7)));
    for (int i = 0; i < 40; i++) send_flit(rand_flit(coll_pkg::alg_doubling, 1'b1));

    test_name = "bcast";
    for (int i = 0; i < comm_entries; i++) write_comm(8'(i), comm_data(int'(2 + rnd() % 2)));
    for (int i = 0; i < 40; i++) send_flit(rand_flit(coll_pkg::alg_bcast, 1'b1));

    ////////////////////
    // mixed stream with writes in between
    test_name = "stream";
    for (int i = 0; i < 200; i++) begin
      f   = rand_flit(coll_pkg::alg_e'(2'(rnd())), (rnd() % 4) != 0);
      sel = int'(rnd() % 8);
      drive_cycle(f, sel == 0, sel == 1, 8'(rnd()), 22'(rnd()));
    end

    test_name = "invalid";
    for (int i = 0; i < 40; i++) send_flit(rand_flit(coll_pkg::alg_e'(2'(rnd())), 1'b0));

    test_name = "drain";
    send_flit('0);  // flush the last two
    send_flit('0);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
